/* Bender.yml */
package:
  name: mem_controller

sources:
  - logic/mem_ctrl_pkg.sv
  - logic/store_buffer.sv
  - logic/byte_sequencer.sv
  - logic/mem_arbiter.sv
  - logic/mem_controller.sv
  - target: test
    files:
      - testbench/tb_byte_ram.sv
      - testbench/tb_mem_controller.sv

/* logic/byte_sequencer.sv */
`timescale 1ns/1ns

module byte_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     burst_start,
    input  mem_ctrl_pkg::burst_req_t burst,
    output logic                     burst_done,
    output mem_ctrl_pkg::word_t      burst_rdata,
    output mem_ctrl_pkg::ram_bus_t   ram,
    input  mem_ctrl_pkg::byte_t      ram_rdata
);

    // latched burst
    logic                  wr_q;
    mem_ctrl_pkg::word_t   data_q;
    mem_ctrl_pkg::addr_t   addr_cnt;
    logic [1:0]            idx;
    logic [1:0]            last_idx;
    logic                  busy;

    // what the RAM bus carries this cycle
    logic                  bus_active;
    logic [1:0]            bus_lane;
    logic                  bus_last;

    // read data returning one cycle later
    logic                  ret_valid;
    logic [1:0]            ret_lane;
    logic                  ret_last;
    logic                  rd_done;
    mem_ctrl_pkg::word_t   rd_word;

    // byte count minus one
    function automatic logic [1:0] burst_last_index(input mem_ctrl_pkg::access_size_t size);
        case (size)
            mem_ctrl_pkg::size_byte: return 2'd0;
            mem_ctrl_pkg::size_half: return 2'd1;
            default:                 return 2'd3;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            bus_active <= 1'b0;
            ram.write  <= 1'b0;
        end else if (burst_start) begin
            // first byte goes out right away
            wr_q       <= burst.write;
            data_q     <= burst.data;
            last_idx   <= burst_last_index(burst.size);
            addr_cnt   <= burst.addr + 1'b1;
            idx        <= 2'd1;
            busy       <= (burst_last_index(burst.size) != 2'd0);
            bus_active <= 1'b1;
            bus_lane   <= 2'd0;
            bus_last   <= (burst_last_index(burst.size) == 2'd0);
            ram.write  <= burst.write;
            ram.addr   <= burst.addr;
            ram.wdata  <= burst.data[7:0];
        end else if (busy) begin
            addr_cnt   <= addr_cnt + 1'b1;
            idx        <= idx + 1'b1;
            busy       <= (idx != last_idx);
            bus_active <= 1'b1;
            bus_lane   <= idx;
            bus_last   <= (idx == last_idx);
            ram.write  <= wr_q;
            ram.addr   <= addr_cnt;
            ram.wdata  <= data_q[8*idx +: 8];
        end else begin
            // address simply holds
            bus_active <= 1'b0;
            ram.write  <= 1'b0;
        end
    end

    // read return pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            ret_valid <= 1'b0;
            rd_done   <= 1'b0;
        end else begin
            ret_valid <= bus_active && !ram.write;
            rd_done   <= ret_valid && ret_last;
        end
        ret_lane <= bus_lane;
        ret_last <= bus_last;
    end

    // little-endian lane assembly, zero above bytes read
    always_ff @(posedge clk) begin
        if (burst_start) begin
            rd_word <= '0;
        end else if (ret_valid) begin
            rd_word[8*ret_lane +: 8] <= ram_rdata;
        end
    end

    // writes finish with their last byte
    assign burst_done  = rd_done || (bus_active && ram.write && bus_last);
    assign burst_rdata = rd_word;

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        burst_start |-> !(busy || bus_active || ret_valid || rd_done))
        else $error("byte sequencer: burst started while another is running");

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_req,
    input  mem_ctrl_pkg::addr_t        fetch_pc,
    output logic                       fetch_valid,
    output mem_ctrl_pkg::word_t        fetch_inst,
    input  logic                       load_req,
    input  mem_ctrl_pkg::load_op_t     load_op,
    input  mem_ctrl_pkg::addr_t        load_addr,
    output logic                       load_valid,
    output mem_ctrl_pkg::word_t        load_value,
    input  logic                       rollback,
    input  logic                       head_valid,
    input  mem_ctrl_pkg::store_entry_t head_entry,
    output logic                       pop,
    output logic                       burst_start,
    output mem_ctrl_pkg::burst_req_t   burst,
    input  logic                       burst_done,
    input  mem_ctrl_pkg::word_t        burst_rdata
);

    typedef enum logic [1:0] {
        own_idle,
        own_fetch,
        own_load,
        own_store
    } owner_t;

    owner_t                  owner;
    owner_t                  pick;
    logic                    squash;

    // pending requests
    logic                    fetch_pend;
    mem_ctrl_pkg::addr_t     fetch_addr_q;
    logic                    load_pend;
    mem_ctrl_pkg::load_op_t  load_op_q;
    mem_ctrl_pkg::addr_t     load_addr_q;

    function automatic mem_ctrl_pkg::access_size_t load_size(input mem_ctrl_pkg::load_op_t op);
        case (op)
            mem_ctrl_pkg::op_lb, mem_ctrl_pkg::op_lbu: return mem_ctrl_pkg::size_byte;
            mem_ctrl_pkg::op_lh, mem_ctrl_pkg::op_lhu: return mem_ctrl_pkg::size_half;
            default:                                   return mem_ctrl_pkg::size_word;
        endcase
    endfunction

    function automatic mem_ctrl_pkg::word_t extend_load(input mem_ctrl_pkg::load_op_t op,
                                                        input mem_ctrl_pkg::word_t raw);
        case (op)
            mem_ctrl_pkg::op_lb:  return {{24{raw[7]}}, raw[7:0]};
            mem_ctrl_pkg::op_lh:  return {{16{raw[15]}}, raw[15:0]};
            mem_ctrl_pkg::op_lbu: return {24'b0, raw[7:0]};
            mem_ctrl_pkg::op_lhu: return {16'b0, raw[15:0]};
            default:              return raw;
        endcase
    endfunction

    // store first, then fetch, then load; rollback hides fetch and load
    always_comb begin
        pick = own_idle;
        if (head_valid) begin
            pick = own_store;
        end else if (fetch_pend && !rollback) begin
            pick = own_fetch;
        end else if (load_pend && !rollback) begin
            pick = own_load;
        end
    end

    assign burst_start = (owner == own_idle) && (pick != own_idle);
    assign pop         = burst_start && (pick == own_store);

    always_comb begin
        case (pick)
            own_store: burst = '{write: 1'b1, addr: head_entry.addr,
                                 size: head_entry.size, data: head_entry.data};
            own_fetch: burst = '{write: 1'b0, addr: fetch_addr_q,
                                 size: mem_ctrl_pkg::size_word, data: '0};
            default:   burst = '{write: 1'b0, addr: load_addr_q,
                                 size: load_size(load_op_q), data: '0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner       <= own_idle;
            squash      <= 1'b0;
            fetch_pend  <= 1'b0;
            load_pend   <= 1'b0;
            fetch_valid <= 1'b0;
            load_valid  <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            load_valid  <= 1'b0;
            if (burst_start && pick == own_fetch) begin
                fetch_pend <= 1'b0;
            end
            if (burst_start && pick == own_load) begin
                load_pend <= 1'b0;
            end
            if (fetch_req) begin
                fetch_pend <= 1'b1;
            end
            if (load_req) begin
                load_pend <= 1'b1;
            end
            if (rollback) begin
                fetch_pend <= 1'b0;
                load_pend  <= 1'b0;
            end
            // owner tracking, a squashed read still runs to its end
            if (burst_start) begin
                owner  <= pick;
                squash <= 1'b0;
            end else if (burst_done) begin
                owner  <= own_idle;
                squash <= 1'b0;
            end else if (rollback && (owner == own_fetch || owner == own_load)) begin
                squash <= 1'b1;
            end
            if (burst_done && !squash && !rollback) begin
                fetch_valid <= (owner == own_fetch);
                load_valid  <= (owner == own_load);
            end
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            fetch_addr_q <= fetch_pc;
        end
        if (load_req) begin
            load_op_q   <= load_op;
            load_addr_q <= load_addr;
        end
        if (burst_done && owner == own_fetch) begin
            fetch_inst <= burst_rdata;
        end
        if (burst_done && owner == own_load) begin
            load_value <= extend_load(load_op_q, burst_rdata);
        end
    end

    // sequencer only finishes a burst this arbiter started
    a_done_owned: assert property (@(posedge clk) disable iff (rst)
        burst_done |-> (owner != own_idle))
        else $error("mem arbiter: burst done with no burst running");

endmodule

/* logic/mem_controller.sv */
`timescale 1ns/1ns

module mem_controller (
    input  logic                       clk,
    input  logic                       rst,
    // byte RAM
    output mem_ctrl_pkg::ram_bus_t     ram,
    input  mem_ctrl_pkg::byte_t        ram_rdata,
    // instruction fetch
    input  logic                       fetch_req,
    input  mem_ctrl_pkg::addr_t        fetch_pc,
    output logic                       fetch_valid,
    output mem_ctrl_pkg::word_t        fetch_inst,
    // loads
    input  logic                       load_req,
    input  mem_ctrl_pkg::load_op_t     load_op,
    input  mem_ctrl_pkg::addr_t        load_addr,
    output logic                       load_valid,
    output mem_ctrl_pkg::word_t        load_value,
    // committed stores
    input  logic                       commit_valid,
    input  mem_ctrl_pkg::store_entry_t commit_store,
    output logic                       buffer_full,
    input  logic                       rollback
);

    logic                       head_valid;
    mem_ctrl_pkg::store_entry_t head_entry;
    logic                       pop;
    logic                       burst_start;
    mem_ctrl_pkg::burst_req_t   burst;
    logic                       burst_done;
    mem_ctrl_pkg::word_t        burst_rdata;

    store_buffer i_store_buffer (
        .clk        (clk),
        .rst        (rst),
        .push       (commit_valid),
        .push_entry (commit_store),
        .pop        (pop),
        .head_valid (head_valid),
        .head_entry (head_entry),
        .full       (buffer_full)
    );

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .load_req    (load_req),
        .load_op     (load_op),
        .load_addr   (load_addr),
        .load_valid  (load_valid),
        .load_value  (load_value),
        .rollback    (rollback),
        .head_valid  (head_valid),
        .head_entry  (head_entry),
        .pop         (pop),
        .burst_start (burst_start),
        .burst       (burst),
        .burst_done  (burst_done),
        .burst_rdata (burst_rdata)
    );

    // sole driver of the RAM bus
    byte_sequencer i_byte_sequencer (
        .clk         (clk),
        .rst         (rst),
        .burst_start (burst_start),
        .burst       (burst),
        .burst_done  (burst_done),
        .burst_rdata (burst_rdata),
        .ram         (ram),
        .ram_rdata   (ram_rdata)
    );

endmodule

/* logic/mem_ctrl_pkg.sv */
package mem_ctrl_pkg;

    // bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // store buffer sizing
    localparam int sb_depth       = 8;
    localparam int sb_index_width = 3;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] word_t;
    typedef logic [7:0]            byte_t;

    // burst length is 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4
    } load_op_t;

    // committed store waiting to drain
    typedef struct packed {
        addr_t        addr;
        word_t        data;
        access_size_t size;
    } store_entry_t;

    // one burst handed to the byte sequencer
    typedef struct packed {
        logic         write;
        addr_t        addr;
        access_size_t size;
        word_t        data;
    } burst_req_t;

    // outputs towards the byte-wide RAM
    typedef struct packed {
        logic  write;
        addr_t addr;
        byte_t wdata;
    } ram_bus_t;

endpackage

/* logic/store_buffer.sv */
`timescale 1ns/1ns

module store_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  mem_ctrl_pkg::store_entry_t push_entry,
    input  logic                       pop,
    output logic                       head_valid,
    output mem_ctrl_pkg::store_entry_t head_entry,
    output logic                       full
);

    typedef logic [mem_ctrl_pkg::sb_index_width-1:0] sb_index_t;

    mem_ctrl_pkg::store_entry_t entries [mem_ctrl_pkg::sb_depth];

    sb_index_t                               head_ptr;
    sb_index_t                               tail_ptr;
    logic [mem_ctrl_pkg::sb_index_width:0]   count;

    // circular increment
    function automatic sb_index_t next_ptr(input sb_index_t ptr);
        if (ptr == sb_index_t'(mem_ctrl_pkg::sb_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (pop) begin
                head_ptr <= next_ptr(head_ptr);
            end
            // push and pop together keep the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail_ptr] <= push_entry;
        end
    end

    assign head_entry = entries[head_ptr];
    assign head_valid = (count != '0);
    assign full       = (count == mem_ctrl_pkg::sb_depth);

    // core must respect buffer_full
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("store buffer: push while full");

    // arbiter only pops a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> head_valid)
        else $error("store buffer: pop while empty");

endmodule

/* mem_controller.f */
logic/mem_ctrl_pkg.sv
logic/store_buffer.sv
logic/byte_sequencer.sv
logic/mem_arbiter.sv
logic/mem_controller.sv
testbench/tb_byte_ram.sv
testbench/tb_mem_controller.sv

/* testbench/tb_byte_ram.sv */
`timescale 1ns/1ns

module tb_byte_ram (
    input  logic                   clk,
    input  mem_ctrl_pkg::ram_bus_t ram,
    output mem_ctrl_pkg::byte_t    rdata
);

    // 1 KiB window, upper address bits ignored
    localparam int depth = 1024;

    mem_ctrl_pkg::byte_t mem [depth];

    initial begin
        rdata = '0;
    end

    // write lands at the edge, read data shows up the cycle after
    always @(posedge clk) begin
        if (ram.write === 1'b1) begin
            mem[ram.addr[9:0]] <= ram.wdata;
        end else begin
            rdata <= mem[ram.addr[9:0]];
        end
    end

    // backdoor preload, only used while the bus is quiet
    task automatic poke(input mem_ctrl_pkg::addr_t addr, input mem_ctrl_pkg::byte_t value);
        mem[addr[9:0]] <= value;
    endtask

endmodule

/* testbench/tb_mem_controller.sv */
`timescale 1ns/1ns

module tb_mem_controller;

    localparam int wait_limit   = 200;
    localparam int quiet_window = 30;

    logic                       clk;
    logic                       rst;
    mem_ctrl_pkg::ram_bus_t     ram;
    mem_ctrl_pkg::byte_t        ram_rdata;
    logic                       fetch_req;
    mem_ctrl_pkg::addr_t        fetch_pc;
    logic                       fetch_valid;
    mem_ctrl_pkg::word_t        fetch_inst;
    logic                       load_req;
    mem_ctrl_pkg::load_op_t     load_op;
    mem_ctrl_pkg::addr_t        load_addr;
    logic                       load_valid;
    mem_ctrl_pkg::word_t        load_value;
    logic                       commit_valid;
    mem_ctrl_pkg::store_entry_t commit_store;
    logic                       buffer_full;
    logic                       rollback;

    // expected RAM contents and the byte writes seen on the bus
    mem_ctrl_pkg::byte_t        mirror [1024];
    mem_ctrl_pkg::ram_bus_t     seen_writes [$];
    mem_ctrl_pkg::ram_bus_t     expected_writes [$];
    logic                       full_seen;
    logic [31:0]                rng_state;

    mem_controller i_mem_controller (
        .clk          (clk),
        .rst          (rst),
        .ram          (ram),
        .ram_rdata    (ram_rdata),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc),
        .fetch_valid  (fetch_valid),
        .fetch_inst   (fetch_inst),
        .load_req     (load_req),
        .load_op      (load_op),
        .load_addr    (load_addr),
        .load_valid   (load_valid),
        .load_value   (load_value),
        .commit_valid (commit_valid),
        .commit_store (commit_store),
        .buffer_full  (buffer_full),
        .rollback     (rollback)
    );

    tb_byte_ram i_byte_ram (
        .clk   (clk),
        .ram   (ram),
        .rdata (ram_rdata)
    );

    always #20 clk = ~clk;

    // bus traffic as the RAM samples it
    always @(posedge clk) begin
        if (!rst && ram.write === 1'b1) begin
            seen_writes.push_back(ram);
        end
        if (!rst && buffer_full) begin
            full_seen = 1'b1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_run($sformatf("[FAIL] %0t ns: %s got %h expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic preload_byte(input mem_ctrl_pkg::addr_t a, input mem_ctrl_pkg::byte_t v);
        i_byte_ram.poke(a, v);
        mirror[a[9:0]] = v;
    endtask

    function automatic mem_ctrl_pkg::byte_t mirror_at(input mem_ctrl_pkg::addr_t a);
        return mirror[a[9:0]];
    endfunction

    // little-endian word from the mirror
    function automatic mem_ctrl_pkg::word_t expected_word(input mem_ctrl_pkg::addr_t a);
        return {mirror_at(a + 3), mirror_at(a + 2), mirror_at(a + 1), mirror_at(a)};
    endfunction

    function automatic mem_ctrl_pkg::word_t expected_load(input mem_ctrl_pkg::load_op_t op,
                                                          input mem_ctrl_pkg::addr_t a);
        int v;
        v = 0;
        case (op)
            mem_ctrl_pkg::op_lb:  v = $signed(mirror_at(a));
            mem_ctrl_pkg::op_lh:  v = $signed({mirror_at(a + 1), mirror_at(a)});
            mem_ctrl_pkg::op_lbu: v = {24'd0, mirror_at(a)};
            mem_ctrl_pkg::op_lhu: v = {16'd0, mirror_at(a + 1), mirror_at(a)};
            default:              v = expected_word(a);
        endcase
        return mem_ctrl_pkg::word_t'(v);
    endfunction

    task automatic do_fetch(input mem_ctrl_pkg::addr_t pc, output mem_ctrl_pkg::word_t inst);
        bit got;
        got = 0;
        @(posedge clk);
        fetch_req <= 1'b1;
        fetch_pc  <= pc;
        @(posedge clk);
        fetch_req <= 1'b0;
        for (int i = 0; i < wait_limit && !got; i++) begin
            @(posedge clk);
            if (fetch_valid) begin
                inst = fetch_inst;
                got  = 1;
            end
        end
        if (!got) begin
            stop_run($sformatf("timeout: fetch at %h was never answered", pc));
        end
    endtask

    task automatic do_load(input mem_ctrl_pkg::load_op_t op, input mem_ctrl_pkg::addr_t a,
                           output mem_ctrl_pkg::word_t value);
        bit got;
        got = 0;
        @(posedge clk);
        load_req  <= 1'b1;
        load_op   <= op;
        load_addr <= a;
        @(posedge clk);
        load_req <= 1'b0;
        for (int i = 0; i < wait_limit && !got; i++) begin
            @(posedge clk);
            if (load_valid) begin
                value = load_value;
                got   = 1;
            end
        end
        if (!got) begin
            stop_run($sformatf("timeout: load at %h was never answered", a));
        end
    endtask

    task automatic check_fetch(input mem_ctrl_pkg::addr_t pc);
        mem_ctrl_pkg::word_t inst;
        do_fetch(pc, inst);
        check_equal(inst, expected_word(pc), $sformatf("fetch at %h", pc));
    endtask

    task automatic check_load(input mem_ctrl_pkg::load_op_t op, input mem_ctrl_pkg::addr_t a);
        mem_ctrl_pkg::word_t value;
        do_load(op, a, value);
        check_equal(value, expected_load(op, a), $sformatf("load op %0d at %h", op, a));
    endtask

    // one committed store, also records the bytes it must write
    task automatic commit_one(input mem_ctrl_pkg::addr_t a, input mem_ctrl_pkg::word_t d,
                              input mem_ctrl_pkg::access_size_t size);
        mem_ctrl_pkg::ram_bus_t w;
        int                     n;
        bit                     room;
        room = 0;
        for (int i = 0; i < wait_limit && !room; i++) begin
            @(posedge clk);
            room = !buffer_full;
        end
        if (!room) begin
            stop_run("timeout: buffer_full never dropped");
        end
        commit_valid      <= 1'b1;
        commit_store.addr <= a;
        commit_store.data <= d;
        commit_store.size <= size;
        @(posedge clk);
        commit_valid <= 1'b0;
        n = (size == mem_ctrl_pkg::size_byte) ? 1 : (size == mem_ctrl_pkg::size_half) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            w.write = 1'b1;
            w.addr  = a + i;
            w.wdata = d[8*i +: 8];
            expected_writes.push_back(w);
            mirror[w.addr[9:0]] = w.wdata;
        end
    endtask

    task automatic drain_and_check();
        bit done;
        done = 0;
        for (int i = 0; i < wait_limit * 4 && !done; i++) begin
            @(negedge clk);
            done = (seen_writes.size() >= expected_writes.size());
        end
        if (!done) begin
            stop_run("timeout: committed stores never reached the RAM");
        end
        // extra bytes would show up here
        repeat (8) @(negedge clk);
        check_equal(seen_writes.size(), expected_writes.size(), "byte write count");
        while (expected_writes.size() > 0) begin
            check_equal(seen_writes.pop_front(), expected_writes.pop_front(), "RAM write");
        end
    endtask

    task automatic expect_quiet();
        for (int i = 0; i < quiet_window; i++) begin
            @(posedge clk);
            if (fetch_valid || load_valid) begin
                stop_run("a rolled back request still returned a result");
            end
        end
    endtask

    task automatic test_fetch();
        // addi x0, x0, 0
        preload_byte(32'h80, 8'h13);
        preload_byte(32'h81, 8'h00);
        preload_byte(32'h82, 8'h00);
        preload_byte(32'h83, 8'h00);
        check_fetch(32'h0000_0000);
        check_fetch(32'h0000_0040);
        check_fetch(32'h0000_0080);
        check_fetch(32'h0000_0123);
        check_fetch(32'h0000_03fc);
    endtask

    task automatic test_loads();
        mem_ctrl_pkg::addr_t bases [3];
        mem_ctrl_pkg::word_t value;
        bases = '{32'h100, 32'h110, 32'h101};
        preload_byte(32'h100, 8'h85);
        preload_byte(32'h101, 8'hf2);
        preload_byte(32'h102, 8'h34);
        preload_byte(32'h103, 8'h9a);
        preload_byte(32'h110, 8'h7f);
        preload_byte(32'h111, 8'h12);
        preload_byte(32'h112, 8'h56);
        preload_byte(32'h113, 8'h78);
        do_load(mem_ctrl_pkg::op_lh, 32'h100, value);
        check_equal(value, 32'hffff_f285, "lh at 100");
        foreach (bases[b]) begin
            for (int op = 0; op < 5; op++) begin
                check_load(mem_ctrl_pkg::load_op_t'(op), bases[b]);
            end
        end
    endtask

    task automatic test_stores();
        commit_one(32'h300, 32'h1122_33a4, mem_ctrl_pkg::size_byte);
        commit_one(32'h306, 32'h0000_c5d6, mem_ctrl_pkg::size_half);
        commit_one(32'h30c, 32'h8899_aabb, mem_ctrl_pkg::size_word);
        drain_and_check();
        check_load(mem_ctrl_pkg::op_lbu, 32'h300);
        check_load(mem_ctrl_pkg::op_lh, 32'h306);
        check_load(mem_ctrl_pkg::op_lw, 32'h30c);
    endtask

    task automatic test_buffer_full();
        full_seen = 1'b0;
        for (int i = 0; i < 20; i++) begin
            commit_one(32'h380 + 4 * i, next_rand(), mem_ctrl_pkg::size_word);
        end
        drain_and_check();
        check_equal(full_seen, 1'b1, "buffer_full reached");
    endtask

    task automatic test_rollback();
        // store drains while fetch and load are cancelled
        commit_one(32'h3e0, next_rand(), mem_ctrl_pkg::size_word);
        fetch_req <= 1'b1;
        fetch_pc  <= 32'h40;
        load_req  <= 1'b1;
        load_op   <= mem_ctrl_pkg::op_lw;
        load_addr <= 32'h100;
        @(posedge clk);
        fetch_req <= 1'b0;
        load_req  <= 1'b0;
        rollback  <= 1'b1;
        @(posedge clk);
        rollback <= 1'b0;
        expect_quiet();
        drain_and_check();
        check_fetch(32'h3e0);
        // read burst already running when rollback hits
        @(posedge clk);
        load_req  <= 1'b1;
        load_op   <= mem_ctrl_pkg::op_lw;
        load_addr <= 32'h110;
        @(posedge clk);
        load_req <= 1'b0;
        @(posedge clk);
        rollback <= 1'b1;
        @(posedge clk);
        rollback <= 1'b0;
        expect_quiet();
        check_fetch(32'h40);
    endtask

    task automatic test_random_mix();
        logic [31:0]                r;
        mem_ctrl_pkg::access_size_t size;
        for (int i = 0; i < 12; i++) begin
            r    = next_rand();
            size = mem_ctrl_pkg::access_size_t'(r[9:8] % 3);
            commit_one(32'h200 + (r & 32'h3f), next_rand(), size);
            drain_and_check();
            r = next_rand();
            check_load(mem_ctrl_pkg::load_op_t'(r % 5), 32'h200 + ((r >> 8) & 32'h3f));
        end
    endtask

    initial begin
        logic [31:0] r;
        clk          = 1'b0;
        rng_state    = 32'h4937_b3f4;
        full_seen    = 1'b0;
        rst          <= 1'b1;
        fetch_req    <= 1'b0;
        fetch_pc     <= '0;
        load_req     <= 1'b0;
        load_op      <= mem_ctrl_pkg::op_lb;
        load_addr    <= '0;
        commit_valid <= 1'b0;
        commit_store <= '0;
        rollback     <= 1'b0;
        for (int a = 0; a < 1024; a++) begin
            r = next_rand();
            preload_byte(a, r[7:0]);
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_equal(buffer_full, 1'b0, "buffer_full after reset");
        check_equal(fetch_valid, 1'b0, "fetch_valid after reset");
        check_equal(load_valid, 1'b0, "load_valid after reset");
        check_equal(ram.write, 1'b0, "ram write after reset");
        test_fetch();
        test_loads();
        test_stores();
        test_buffer_full();
        test_rollback();
        test_random_mix();
        $display("Test OK");
        $finish;
    end

endmodule
